/* udp_tx.f */
udp_tx_pkg.sv
crc32_d8.sv
ip_checksum.sv
header_gen.sv
frame_ctrl.sv
gmii_tx_stage.sv
udp_tx_top.sv
udp_tx_checker.sv
udp_tx_tb.sv

/* udp_tx_tb.sv */
// payload source answers every request at once; expected frames come from a bitwise model
`timescale 1ns/1ps

module udp_tx_tb;

    localparam int NUM_CASES = 7;
    localparam int MAX_FRAME = 1530;

    typedef struct {
        int          len;
        logic [47:0] mac_dst;
        logic [47:0] mac_src;
        logic [31:0] ip_src;
        logic [31:0] ip_dst;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [7:0]  pay_seed;
        bit          restart;
        int          frame_len;
    } case_t;

    logic                         clk;
    logic                         rst_n;
    logic                         i_start;
    logic [47:0]                  i_mac_dst;
    logic [47:0]                  i_mac_src;
    logic [31:0]                  i_ip_src;
    logic [31:0]                  i_ip_dst;
    logic [15:0]                  i_udp_src_port;
    logic [15:0]                  i_udp_dst_port;
    logic [udp_tx_pkg::LEN_W-1:0] i_payload_len;
    logic [7:0]                   i_payload;
    logic                         o_payload_req;
    logic                         o_tx_done;
    logic                         o_busy;
    logic                         o_gmii_tx_en;
    logic [7:0]                   o_gmii_txd;

    case_t      cases [NUM_CASES];
    logic [7:0] exp_bytes [MAX_FRAME];
    logic [7:0] pay_bytes [udp_tx_pkg::MAX_PAYLOAD];
    int         exp_len;
    int         data_errors;
    int         ctrl_errors;
    bit         table_ready;

    udp_tx_top DUT (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic report_byte(input int idx, input int got, input int exp_val);
        data_errors++;
        $display("ERR @%0t: frame byte %0d got 0x%02h expected 0x%02h",
                 $time, idx, got, exp_val);
    endtask

    task automatic flag_control(input string what, input int got, input int exp_val);
        ctrl_errors++;
        $display("ERR @%0t: %s got %0d expected %0d", $time, what, got, exp_val);
    endtask

    function automatic void push_byte(input logic [7:0] b);
        exp_bytes[exp_len] = b;
        exp_len++;
    endfunction

    // preamble, headers, payload, padding, then fcs over bytes 8 onward
    function automatic void build_frame(input int c);
        logic [31:0] sum;
        logic [31:0] crc;
        exp_len = 0;
        for (int k = 0; k < cases[c].len; k++) begin
            pay_bytes[k] = 8'($urandom) ^ cases[c].pay_seed;
        end
        for (int k = 0; k < 7; k++) push_byte(8'h55);
        push_byte(8'hD5);
        for (int k = 5; k >= 0; k--) push_byte(cases[c].mac_dst[8*k +: 8]);
        for (int k = 5; k >= 0; k--) push_byte(cases[c].mac_src[8*k +: 8]);
        push_byte(8'h08);
        push_byte(8'h00);
        push_byte(8'h45);
        push_byte(8'h00);
        push_byte(8'((cases[c].len + 28) >> 8));
        push_byte(8'(cases[c].len + 28));
        for (int k = 0; k < 4; k++) push_byte(8'h00);
        push_byte(8'd64);
        push_byte(8'd17);
        push_byte(8'h00);
        push_byte(8'h00);
        for (int k = 3; k >= 0; k--) push_byte(cases[c].ip_src[8*k +: 8]);
        for (int k = 3; k >= 0; k--) push_byte(cases[c].ip_dst[8*k +: 8]);
        // ipv4 header occupies bytes 22..41
        sum = 0;
        for (int k = 22; k < 42; k += 2) sum = sum + {exp_bytes[k], exp_bytes[k+1]};
        while (sum[31:16] != 0) sum = sum[15:0] + sum[31:16];
        exp_bytes[32] = ~sum[15:8];
        exp_bytes[33] = ~sum[7:0];
        push_byte(cases[c].src_port[15:8]);
        push_byte(cases[c].src_port[7:0]);
        push_byte(cases[c].dst_port[15:8]);
        push_byte(cases[c].dst_port[7:0]);
        push_byte(8'((cases[c].len + 8) >> 8));
        push_byte(8'(cases[c].len + 8));
        push_byte(8'h00);
        push_byte(8'h00);
        for (int k = 0; k < cases[c].len; k++) push_byte(pay_bytes[k]);
        for (int k = cases[c].len; k < 18; k++) push_byte(8'h00);
        crc = 32'hFFFF_FFFF;
        for (int k = 8; k < exp_len; k++) begin
            for (int b = 0; b < 8; b++) begin
                if (crc[0] ^ exp_bytes[k][b]) crc = (crc >> 1) ^ 32'hEDB8_8320;
                else crc = crc >> 1;
            end
        end
        crc = ~crc;
        for (int k = 0; k < 4; k++) push_byte(crc[8*k +: 8]);
    endfunction

    task automatic run_case(input int c);
        int cyc;
        int nbytes;
        int first_cyc;
        int last_cyc;
        int req_cnt;
        bit done_seen;
        build_frame(c);
        @(negedge clk);
        if (o_busy !== 1'b0) flag_control("o_busy before start", o_busy, 0);
        i_mac_dst      = cases[c].mac_dst;
        i_mac_src      = cases[c].mac_src;
        i_ip_src       = cases[c].ip_src;
        i_ip_dst       = cases[c].ip_dst;
        i_udp_src_port = cases[c].src_port;
        i_udp_dst_port = cases[c].dst_port;
        i_payload_len  = 16'(cases[c].len);
        i_start        = 1'b1;
        @(negedge clk);
        i_start   = 1'b0;
        cyc       = 0;
        nbytes    = 0;
        first_cyc = -1;
        last_cyc  = -1;
        req_cnt   = 0;
        done_seen = 1'b0;
        while (!done_seen && cyc < cases[c].frame_len + 8) begin
            if (cyc == 0 && o_busy !== 1'b1) flag_control("o_busy after start", o_busy, 1);
            if (o_gmii_tx_en) begin
                if (first_cyc < 0)
                    first_cyc = cyc;
                else if (cyc != last_cyc + 1)
                    flag_control("gap in tx_en at cycle", cyc, last_cyc + 1);
                last_cyc = cyc;
                if (nbytes >= exp_len)
                    flag_control("byte beyond frame end", nbytes, exp_len - 1);
                else if (o_gmii_txd !== exp_bytes[nbytes])
                    report_byte(nbytes, o_gmii_txd, exp_bytes[nbytes]);
                nbytes++;
            end
            if (o_payload_req) begin
                i_payload = (req_cnt < cases[c].len) ? pay_bytes[req_cnt] : 8'h00;
                req_cnt++;
            end
            if (o_tx_done) begin
                done_seen = 1'b1;
                if (nbytes != exp_len) flag_control("bytes sent when done pulsed", nbytes, exp_len);
            end
            // a start while busy, with other fields, must be ignored
            if (cases[c].restart && cyc == 20) begin
                i_start       = 1'b1;
                i_mac_dst     = ~cases[c].mac_dst;
                i_payload_len = 16'd5;
            end else begin
                i_start = 1'b0;
            end
            cyc++;
            @(negedge clk);
        end
        if (!done_seen) begin
            ctrl_errors++;
            $display("case %0d: o_tx_done never pulsed before the frame limit", c);
        end
        if (first_cyc != 1) flag_control("cycle of first preamble byte", first_cyc, 1);
        if (nbytes != cases[c].frame_len) flag_control("frame length", nbytes, cases[c].frame_len);
        if (req_cnt != cases[c].len) flag_control("payload request cycles", req_cnt, cases[c].len);
        repeat (6) begin
            if ({o_busy, o_gmii_tx_en, o_tx_done, o_payload_req} !== 4'b0000)
                flag_control("outputs after frame end",
                             {o_busy, o_gmii_tx_en, o_tx_done, o_payload_req}, 0);
            @(negedge clk);
        end
    endtask

    initial begin
        data_errors    = 0;
        ctrl_errors    = 0;
        table_ready    = 1'b0;
        rst_n          = 1'b0;
        i_start        = 1'b0;
        i_mac_dst      = '0;
        i_mac_src      = '0;
        i_ip_src       = '0;
        i_ip_dst       = '0;
        i_udp_src_port = '0;
        i_udp_dst_port = '0;
        i_payload_len  = '0;
        i_payload      = '0;
        void'($urandom(32'hf6cb));
        // len, dst mac, src mac, src ip, dst ip, ports, payload seed, restart, frame length
        cases[0] = '{0, 48'h0200_0000_0001, 48'h0200_0000_00aa, 32'hc0a8_0001, 32'hc0a8_0002,
                     16'd1024, 16'd5000, 8'h00, 1'b0, 72};
        cases[1] = '{1, 48'hffff_ffff_ffff, 48'h0012_3456_789a, 32'h0a00_0001, 32'h0aff_ffff,
                     16'd68, 16'd67, 8'h3c, 1'b1, 72};
        cases[2] = '{17, 48'h00a0_c9de_ad01, 48'h00a0_c9be_ef02, 32'hac10_0505, 32'hac10_0a0a,
                     16'hfffe, 16'h0001, 8'h5a, 1'b0, 72};
        cases[3] = '{18, 48'h0123_4567_89ab, 48'hcdef_0123_4567, 32'hffff_fffe, 32'h8000_0001,
                     16'd53, 16'd53, 8'hc3, 1'b0, 72};
        cases[4] = '{19, 48'h5e00_0000_0000, 48'h00ee_eeee_eeee, 32'h7f00_0001, 32'h7f00_0001,
                     16'd9, 16'd9, 8'h81, 1'b0, 73};
        cases[5] = '{100, 48'h0800_2712_3456, 48'h0800_27ab_cdef, 32'hc0a8_6401, 32'he000_00fb,
                     16'd5353, 16'd5353, 8'hf0, 1'b1, 154};
        cases[6] = '{1472, 48'h0002_b3aa_bbcc, 48'h0002_b3dd_eeff, 32'h0102_0304, 32'hfefd_fcfb,
                     16'd4000, 16'd4001, 8'h17, 1'b0, 1526};
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end
        $display("errors: data=%0d control=%0d assertion=%0d",
                 data_errors, ctrl_errors, DUT.u_checker.violations);
        if (data_errors + ctrl_errors + DUT.u_checker.violations == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // limit from the table: every frame plus per-case overhead, plus reset
    initial begin
        int total_cycles;
        wait (table_ready);
        total_cycles = 100;
        for (int c = 0; c < NUM_CASES; c++) begin
            total_cycles += cases[c].frame_len + 20;
        end
        #(total_cycles * 10);
        $display("timeout: the run did not finish within %0d ns", total_cycles * 10);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* udp_tx_checker.sv */
// bound to udp_tx_top; tx_en may only rise two cycles after an accepted start
`timescale 1ns/1ps

module udp_tx_checker (
    input logic clk,
    input logic rst_n,
    input logic i_start,
    input logic i_busy,
    input logic i_payload_req,
    input logic i_tx_done,
    input logic i_gmii_tx_en
);

    // read by the testbench at the end of the run
    int violations = 0;

    a_done_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        i_tx_done |-> i_gmii_tx_en)
        else begin
            violations++;
            $error("o_tx_done high while o_gmii_tx_en is low");
        end

    a_req_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        i_payload_req |-> i_busy)
        else begin
            violations++;
            $error("o_payload_req high while o_busy is low");
        end

    // a new frame needs an accepted start two cycles earlier
    a_tx_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_gmii_tx_en) |-> $past(i_start && !i_busy, 2))
        else begin
            violations++;
            $error("o_gmii_tx_en rose without an accepted start");
        end

endmodule

bind udp_tx_top udp_tx_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start       (i_start),
    .i_busy        (o_busy),
    .i_payload_req (o_payload_req),
    .i_tx_done     (o_tx_done),
    .i_gmii_tx_en  (o_gmii_tx_en)
);

/* udp_tx_top.sv */
// no back-pressure: a payload byte must be on i_payload every cycle that o_payload_req is high
`timescale 1ns/1ps

module udp_tx_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_start,
    input  logic [47:0]                     i_mac_dst,
    input  logic [47:0]                     i_mac_src,
    input  logic [31:0]                     i_ip_src,
    input  logic [31:0]                     i_ip_dst,
    input  logic [15:0]                     i_udp_src_port,
    input  logic [15:0]                     i_udp_dst_port,
    input  logic [udp_tx_pkg::LEN_W-1:0]    i_payload_len,
    input  logic [7:0]                      i_payload,
    output logic                            o_payload_req,
    output logic                            o_tx_done,
    output logic                            o_busy,
    output logic                            o_gmii_tx_en,
    output logic [7:0]                      o_gmii_txd
);

    udp_tx_pkg::tx_phase_t          phase;
    logic [udp_tx_pkg::LEN_W-1:0]   index;
    logic                           start_accept;
    logic [7:0]                     hdr_byte;
    logic [15:0]                    ip_total_len;
    logic [31:0]                    ip_src;
    logic [31:0]                    ip_dst;
    logic [15:0]                    checksum;
    logic                           crc_init;
    logic                           crc_en;
    logic [7:0]                     crc_data;
    logic [31:0]                    crc;

    frame_ctrl u_frame_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_start        (i_start),
        .i_payload_len  (i_payload_len),
        .o_phase        (phase),
        .o_index        (index),
        .o_start_accept (start_accept),
        .o_payload_req  (o_payload_req),
        .o_tx_done      (o_tx_done),
        .o_busy         (o_busy)
    );

    header_gen u_header_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_start_accept (start_accept),
        .i_mac_dst      (i_mac_dst),
        .i_mac_src      (i_mac_src),
        .i_ip_src       (i_ip_src),
        .i_ip_dst       (i_ip_dst),
        .i_udp_src_port (i_udp_src_port),
        .i_udp_dst_port (i_udp_dst_port),
        .i_payload_len  (i_payload_len),
        .i_index        (index),
        .i_checksum     (checksum),
        .o_hdr_byte     (hdr_byte),
        .o_ip_total_len (ip_total_len),
        .o_ip_src       (ip_src),
        .o_ip_dst       (ip_dst)
    );

    ip_checksum u_ip_checksum (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_start_accept (start_accept),
        .i_ip_total_len (ip_total_len),
        .i_ip_src       (ip_src),
        .i_ip_dst       (ip_dst),
        .o_checksum     (checksum)
    );

    gmii_tx_stage u_gmii_tx_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_phase        (phase),
        .i_index        (index),
        .i_hdr_byte     (hdr_byte),
        .i_payload      (i_payload),
        .i_crc          (crc),
        .o_crc_init     (crc_init),
        .o_crc_en       (crc_en),
        .o_crc_data     (crc_data),
        .o_gmii_txd     (o_gmii_txd),
        .o_gmii_tx_en   (o_gmii_tx_en)
    );

    crc32_d8 u_crc32_d8 (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_init         (crc_init),
        .i_en           (crc_en),
        .i_data         (crc_data),
        .o_crc          (crc)
    );

endmodule

/* gmii_tx_stage.sv */
// payload byte is taken the cycle after its request; fcs goes out least significant byte first
`timescale 1ns/1ps

module gmii_tx_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  udp_tx_pkg::tx_phase_t           i_phase,
    input  logic [udp_tx_pkg::LEN_W-1:0]    i_index,
    input  logic [7:0]                      i_hdr_byte,
    input  logic [7:0]                      i_payload,
    input  logic [31:0]                     i_crc,
    output logic                            o_crc_init,
    output logic                            o_crc_en,
    output logic [7:0]                      o_crc_data,
    output logic [7:0]                      o_gmii_txd,
    output logic                            o_gmii_tx_en
);

    logic [7:0] payload_q;
    logic [7:0] tx_byte;

    always_ff @(posedge clk) begin
        payload_q <= i_payload;
    end

    // pad and idle both send zero
    always_comb begin
        case (i_phase)
            udp_tx_pkg::PH_PREAMBLE: begin
                if (i_index == udp_tx_pkg::PREAMBLE_LEN - 1) begin
                    tx_byte = udp_tx_pkg::SFD_BYTE;
                end else begin
                    tx_byte = udp_tx_pkg::PREAMBLE_BYTE;
                end
            end
            udp_tx_pkg::PH_HEADER:  tx_byte = i_hdr_byte;
            udp_tx_pkg::PH_PAYLOAD: tx_byte = payload_q;
            udp_tx_pkg::PH_FCS:     tx_byte = i_crc[8*i_index[1:0] +: 8];
            default:                tx_byte = 8'h00;
        endcase
    end

    assign o_crc_init = (i_phase == udp_tx_pkg::PH_PREAMBLE);
    assign o_crc_en   = (i_phase == udp_tx_pkg::PH_HEADER) ||
                        (i_phase == udp_tx_pkg::PH_PAYLOAD) ||
                        (i_phase == udp_tx_pkg::PH_PAD);
    assign o_crc_data = tx_byte;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_gmii_txd   <= 8'h00;
            o_gmii_tx_en <= 1'b0;
        end else begin
            o_gmii_txd   <= tx_byte;
            o_gmii_tx_en <= (i_phase != udp_tx_pkg::PH_IDLE);
        end
    end

endmodule

/* frame_ctrl.sv */
// start is a one-cycle pulse and is dropped while busy; payload length must not exceed 1472
`timescale 1ns/1ps

module frame_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_start,
    input  logic [udp_tx_pkg::LEN_W-1:0]    i_payload_len,
    output udp_tx_pkg::tx_phase_t           o_phase,
    output logic [udp_tx_pkg::LEN_W-1:0]    o_index,
    output logic                            o_start_accept,
    output logic                            o_payload_req,
    output logic                            o_tx_done,
    output logic                            o_busy
);

    logic [udp_tx_pkg::LEN_W-1:0] len_q;
    logic [udp_tx_pkg::LEN_W-1:0] index_d;
    udp_tx_pkg::tx_phase_t        phase_d;
    logic                         last_byte;

    assign o_start_accept = i_start && !o_busy;

    // last index of the current phase
    always_comb begin
        case (o_phase)
            udp_tx_pkg::PH_PREAMBLE: last_byte = (o_index == udp_tx_pkg::PREAMBLE_LEN - 1);
            udp_tx_pkg::PH_HEADER:   last_byte = (o_index == udp_tx_pkg::HDR_LEN - 1);
            udp_tx_pkg::PH_PAYLOAD:  last_byte = (o_index == len_q - 1'b1);
            udp_tx_pkg::PH_PAD:      last_byte = (o_index + len_q == udp_tx_pkg::MIN_PAYLOAD - 1);
            udp_tx_pkg::PH_FCS:      last_byte = (o_index == udp_tx_pkg::FCS_LEN - 1);
            default:                 last_byte = 1'b0;
        endcase
    end

    always_comb begin
        phase_d = o_phase;
        index_d = o_index + 1'b1;
        if (o_phase == udp_tx_pkg::PH_IDLE) begin
            index_d = '0;
            if (o_start_accept) begin
                phase_d = udp_tx_pkg::PH_PREAMBLE;
            end
        end else if (last_byte) begin
            index_d = '0;
            case (o_phase)
                udp_tx_pkg::PH_PREAMBLE: phase_d = udp_tx_pkg::PH_HEADER;
                udp_tx_pkg::PH_HEADER: begin
                    // empty payload goes straight to padding
                    if (len_q == '0) begin
                        phase_d = udp_tx_pkg::PH_PAD;
                    end else begin
                        phase_d = udp_tx_pkg::PH_PAYLOAD;
                    end
                end
                udp_tx_pkg::PH_PAYLOAD: begin
                    if (len_q < udp_tx_pkg::MIN_PAYLOAD) begin
                        phase_d = udp_tx_pkg::PH_PAD;
                    end else begin
                        phase_d = udp_tx_pkg::PH_FCS;
                    end
                end
                udp_tx_pkg::PH_PAD: phase_d = udp_tx_pkg::PH_FCS;
                default:            phase_d = udp_tx_pkg::PH_IDLE;
            endcase
        end
    end

    // request runs one cycle ahead of the payload phase
    // so the sampled byte is ready when its phase slot comes up
    assign o_payload_req = (o_phase == udp_tx_pkg::PH_HEADER && last_byte && len_q != '0) ||
                           (o_phase == udp_tx_pkg::PH_PAYLOAD && !last_byte);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_phase   <= udp_tx_pkg::PH_IDLE;
            o_index   <= '0;
            o_tx_done <= 1'b0;
            o_busy    <= 1'b0;
        end else begin
            o_phase   <= phase_d;
            o_index   <= index_d;
            // lines up with the last fcs byte on gmii
            o_tx_done <= (o_phase == udp_tx_pkg::PH_FCS) && last_byte;
            if (o_start_accept) begin
                o_busy <= 1'b1;
            end else if (o_tx_done) begin
                o_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_start_accept) begin
            len_q <= i_payload_len;
        end
    end

endmodule

/* header_gen.sv */
// fields are held from the accepted start until the next one; header byte is valid for index 0..41 only
`timescale 1ns/1ps

module header_gen (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_start_accept,
    input  logic [47:0]                     i_mac_dst,
    input  logic [47:0]                     i_mac_src,
    input  logic [31:0]                     i_ip_src,
    input  logic [31:0]                     i_ip_dst,
    input  logic [15:0]                     i_udp_src_port,
    input  logic [15:0]                     i_udp_dst_port,
    input  logic [udp_tx_pkg::LEN_W-1:0]    i_payload_len,
    input  logic [udp_tx_pkg::LEN_W-1:0]    i_index,
    input  logic [15:0]                     i_checksum,
    output logic [7:0]                      o_hdr_byte,
    output logic [15:0]                     o_ip_total_len,
    output logic [31:0]                     o_ip_src,
    output logic [31:0]                     o_ip_dst
);

    logic [47:0] mac_dst_q;
    logic [47:0] mac_src_q;
    logic [15:0] src_port_q;
    logic [15:0] dst_port_q;
    logic [15:0] udp_len_q;
    logic [8*udp_tx_pkg::HDR_LEN-1:0] hdr_flat;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac_dst_q      <= '0;
            mac_src_q      <= '0;
            o_ip_src       <= '0;
            o_ip_dst       <= '0;
            src_port_q     <= '0;
            dst_port_q     <= '0;
            o_ip_total_len <= '0;
            udp_len_q      <= '0;
        end else if (i_start_accept) begin
            mac_dst_q      <= i_mac_dst;
            mac_src_q      <= i_mac_src;
            o_ip_src       <= i_ip_src;
            o_ip_dst       <= i_ip_dst;
            src_port_q     <= i_udp_src_port;
            dst_port_q     <= i_udp_dst_port;
            o_ip_total_len <= i_payload_len +
                              16'(udp_tx_pkg::IP_HDR_LEN + udp_tx_pkg::UDP_HDR_LEN);
            udp_len_q      <= i_payload_len + 16'(udp_tx_pkg::UDP_HDR_LEN);
        end
    end

    // whole header in network order, first byte at the top
    assign hdr_flat = {
        mac_dst_q, mac_src_q, udp_tx_pkg::ETH_TYPE_IPV4,
        udp_tx_pkg::IP_VER_IHL, 8'h00, o_ip_total_len,
        16'h0000, 16'h0000,
        udp_tx_pkg::IP_TTL, udp_tx_pkg::IP_PROTO_UDP, i_checksum,
        o_ip_src, o_ip_dst,
        src_port_q, dst_port_q, udp_len_q, 16'h0000
    };

    always_comb begin
        if (i_index < udp_tx_pkg::HDR_LEN) begin
            o_hdr_byte = hdr_flat[8*(udp_tx_pkg::HDR_LEN - 1 - i_index) +: 8];
        end else begin
            o_hdr_byte = 8'h00;
        end
    end

endmodule

/* ip_checksum.sv */
// sum starts one cycle after the strobe, when the captured fields are stable; result valid 11 cycles on
`timescale 1ns/1ps

module ip_checksum (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_start_accept,
    input  logic [15:0] i_ip_total_len,
    input  logic [31:0] i_ip_src,
    input  logic [31:0] i_ip_dst,
    output logic [15:0] o_checksum
);

    logic        active;
    logic [3:0]  word_cnt;
    logic [19:0] sum;
    logic [15:0] word;
    logic [16:0] fold1;
    logic [15:0] fold2;

    // header words in order, checksum field counted as zero
    always_comb begin
        case (word_cnt)
            4'd0:    word = {udp_tx_pkg::IP_VER_IHL, 8'h00};
            4'd1:    word = i_ip_total_len;
            4'd4:    word = {udp_tx_pkg::IP_TTL, udp_tx_pkg::IP_PROTO_UDP};
            4'd6:    word = i_ip_src[31:16];
            4'd7:    word = i_ip_src[15:0];
            4'd8:    word = i_ip_dst[31:16];
            4'd9:    word = i_ip_dst[15:0];
            default: word = 16'h0000;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            word_cnt <= '0;
            sum      <= '0;
        end else if (i_start_accept) begin
            active   <= 1'b1;
            word_cnt <= '0;
            sum      <= '0;
        end else if (active) begin
            sum      <= sum + {4'h0, word};
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == udp_tx_pkg::IP_HDR_LEN / 2 - 1) begin
                active <= 1'b0;
            end
        end
    end

    // two folds cover the worst case carry
    assign fold1      = {1'b0, sum[15:0]} + {13'h0, sum[19:16]};
    assign fold2      = fold1[15:0] + {15'h0, fold1[16]};
    assign o_checksum = ~fold2;

endmodule

/* crc32_d8.sv */
// lsb-first ethernet crc-32 over one byte per enabled clock; init wins over enable
`timescale 1ns/1ps

module crc32_d8 (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_init,
    input  logic        i_en,
    input  logic [7:0]  i_data,
    output logic [31:0] o_crc
);

    logic [31:0] crc_q;

    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ udp_tx_pkg::CRC_POLY_REFL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_q <= udp_tx_pkg::CRC_INIT;
        end else if (i_init) begin
            crc_q <= udp_tx_pkg::CRC_INIT;
        end else if (i_en) begin
            crc_q <= crc_step(crc_q, i_data);
        end
    end

    // fcs is the inverted register
    assign o_crc = ~crc_q;

endmodule

/* udp_tx_pkg.sv */
// constants for an untagged Ethernet II / IPv4 / UDP frame, no IP options, UDP checksum left at zero
package udp_tx_pkg;

    // byte counts of the frame sections
    localparam int PREAMBLE_LEN = 8;
    localparam int MAC_HDR_LEN  = 14;
    localparam int IP_HDR_LEN   = 20;
    localparam int UDP_HDR_LEN  = 8;
    localparam int HDR_LEN      = MAC_HDR_LEN + IP_HDR_LEN + UDP_HDR_LEN;
    localparam int FCS_LEN      = 4;

    // 46 byte minimum MAC data field less the IP and UDP headers
    localparam int MIN_PAYLOAD  = 46 - IP_HDR_LEN - UDP_HDR_LEN;

    // payload length and byte index width
    localparam int LEN_W        = 16;
    localparam int MAX_PAYLOAD  = 1472;

    // fixed bytes
    localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0]  SFD_BYTE      = 8'hD5;
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;

    // ipv4 fields, tos, id and fragment are zero
    localparam logic [7:0]  IP_VER_IHL    = 8'h45;
    localparam logic [7:0]  IP_TTL        = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;

    // ethernet crc-32, lsb-first form
    localparam logic [31:0] CRC_POLY_REFL = 32'hEDB8_8320;
    localparam logic [31:0] CRC_INIT      = 32'hFFFF_FFFF;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_PREAMBLE,
        PH_HEADER,
        PH_PAYLOAD,
        PH_PAD,
        PH_FCS
    } tx_phase_t;

endpackage
